// ==== tb.f ====
hdl/split_mult_pkg.sv
hdl/pp_if.sv
hdl/sub_mult.sv
hdl/pp_generator.sv
hdl/cross_sum_stage.sv
hdl/product_combiner.sv
hdl/split_mult16.sv
test/split_mult16_properties.sv
test/tb_split_mult16.sv

// ==== Makefile ====
TOP := tb_split_mult16

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// ==== test/tb_split_mult16.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_split_mult16;
    import split_mult_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int N_CORNER     = 7;
    localparam int N_BOUND      = 8;
    localparam int N_STREAM     = 200;
    localparam int N_GAP        = 150;
    localparam int N_TESTS      = 4;
    localparam int DRAIN_CYCLES = 4;  // idle cycles until the last result leaves.
    localparam int TOTAL_VECTORS = RESET_CYCLES + 1 + N_CORNER + N_BOUND + N_STREAM + N_GAP
                                 + N_TESTS * DRAIN_CYCLES;
    localparam int WATCHDOG_NS = (TOTAL_VECTORS + 20) * CLK_PERIOD;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t p;

    integer   seed = 32'h941a_0243;
    int       cycle = 0;
    int       got_count = 0;  // results seen so far, also the read index.
    product_t exp_q[$];
    int       due_q[$];       // cycle in which each result must show up.

    split_mult16 #(.LO_W(A_LO_DEFAULT)) DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .p         (p)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check(input logic [63:0] expected, input logic [63:0] actual,
                         input string what);
        if (expected !== actual) begin
            $display("** Error at %0d ns: %s mismatch, expected %0h, got %0h",
                     $time, what, expected, actual);
            fail_run();
        end
    endtask

    // every result is due exactly three edges after it was sampled.
    always @(negedge clk) begin : result_monitor
        logic exp_valid;
        exp_valid = 1'b0;
        if (got_count < exp_q.size()) begin
            if (due_q[got_count] == cycle)
                exp_valid = 1'b1;
        end
        check(64'(exp_valid), 64'(out_valid), "out_valid");
        if (exp_valid) begin
            check(64'(exp_q[got_count]), 64'(p), "product");
            got_count = got_count + 1;
        end
    end

    task automatic drive_pair(input operand_t x, input operand_t y);
        @(negedge clk);
        in_valid = 1'b1;
        a = x;
        b = y;
        exp_q.push_back({16'h0000, x} * {16'h0000, y});
        due_q.push_back(cycle + 3);  // sampled at the next edge.
    endtask

    task automatic drive_idle();
        logic [31:0] r;
        r = $random(seed);
        @(negedge clk);
        in_valid = 1'b0;
        a = r[15:0];  // junk, must be ignored.
        b = r[31:16];
    endtask

    task automatic drain_and_count(input string name, input int got_before,
                                   input int n_accepted);
        repeat (DRAIN_CYCLES) begin
            drive_idle();
        end
        check(64'(n_accepted), 64'(got_count - got_before), {name, " result count"});
    endtask

    task automatic reset_test();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check(64'(1'b0), 64'(out_valid), "out_valid in reset");
            in_valid = 1'b1;  // must not get through while in reset.
        end
        arst_n = 1'b1;
        in_valid = 1'b0;
        @(negedge clk);
        check(64'(1'b0), 64'(out_valid), "out_valid after reset");
    endtask

    task automatic corner_test();
        int got_before;
        got_before = got_count;
        drive_pair(16'h0000, 16'h0000);
        drive_pair(16'h0000, 16'hffff);
        drive_pair(16'hffff, 16'h0000);
        drive_pair(16'h0001, 16'habcd);
        drive_pair(16'h1234, 16'h0001);
        drive_pair(16'hffff, 16'hffff);
        drive_pair(16'h8000, 16'h8000);
        drain_and_count("corner", got_before, N_CORNER);
    endtask

    // operands sitting right on the 7 bit split.
    task automatic boundary_test();
        int got_before;
        got_before = got_count;
        drive_pair(16'h007f, 16'h007f);
        drive_pair(16'h0080, 16'h0080);
        drive_pair(16'h007f, 16'h0080);
        drive_pair(16'h00ff, 16'h00ff);
        drive_pair(16'hff80, 16'hff80);
        drive_pair(16'hff80, 16'h007f);
        drive_pair(16'h007f, 16'hff80);
        drive_pair(16'hff7f, 16'h0081);
        drain_and_count("boundary", got_before, N_BOUND);
    endtask

    task automatic stream_test();
        logic [31:0] r;
        int          got_before;
        got_before = got_count;
        for (int i = 0; i < N_STREAM; i++) begin
            r = $random(seed);
            drive_pair(r[15:0], r[31:16]);
        end
        drain_and_count("stream", got_before, N_STREAM);
    endtask

    task automatic gap_test();
        logic [31:0] r;
        int          got_before;
        int          n_acc;
        got_before = got_count;
        n_acc = 0;
        for (int i = 0; i < N_GAP; i++) begin
            r = $random(seed);
            if (r[1:0] != 2'b00) begin  // about one cycle in four stays idle.
                drive_pair(r[17:2], r[31:16]);
                n_acc++;
            end else begin
                drive_idle();
            end
        end
        drain_and_count("gap", got_before, n_acc);
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        reset_test();
        corner_test();
        boundary_test();
        stream_test();
        gap_test();
        if (got_count == exp_q.size()) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("some accepted inputs never produced a result");
            fail_run();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        fail_run();
    end

endmodule

`default_nettype wire

// ==== test/split_mult16_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// valid timing and reset checks at the multiplier boundary.
module split_mult16_properties (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic out_valid
);

    // nothing leaves the pipeline while it is held in reset.
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    // three register stages between in_valid and out_valid.
    valid_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid & arst_n, 3)
    ) else $error("out_valid is not in_valid delayed by three cycles");

endmodule

bind split_mult16 split_mult16_properties u_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== hdl/split_mult16.sv ====
`timescale 1ns/1ps
`default_nettype none

// 16x16 unsigned multiplier, three register stages deep.
module split_mult16 #(
    parameter int LO_W = split_mult_pkg::A_LO_DEFAULT
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  split_mult_pkg::operand_t a,
    input  split_mult_pkg::operand_t b,
    output logic                     out_valid,
    output split_mult_pkg::product_t p
);

    pp_if    pp_bus ();
    cross_if cs_bus ();

    pp_generator #(.LO_W(LO_W)) u_pp_generator (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .pp       (pp_bus.src)
    );

    cross_sum_stage u_cross_sum_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .pp     (pp_bus.dst),
        .cs     (cs_bus.src)
    );

    product_combiner #(.LO_W(LO_W)) u_product_combiner (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (cs_bus.dst),
        .out_valid (out_valid),
        .p         (p)
    );

endmodule

`default_nettype wire

// ==== hdl/product_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_combiner #(
    parameter int LO_W = split_mult_pkg::A_LO_DEFAULT
) (
    input  logic                     clk,
    input  logic                     arst_n,
    cross_if.dst                     cs,
    output logic                     out_valid,
    output split_mult_pkg::product_t p
);
    import split_mult_pkg::*;

    // everything above the low LO_W bits.
    localparam int UP_W = PROD_W - LO_W;

    logic [UP_W-1:0] upper_sum;

    // hh sits at 2*LO_W, cross at LO_W, upper half of ll joins the add.
    assign upper_sum = (UP_W'(cs.p_hh) << LO_W)
                     + UP_W'(cs.p_cross)
                     + UP_W'(cs.p_ll >> LO_W);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            p         <= '0;
        end else begin
            out_valid <= cs.valid;
            p         <= {upper_sum, cs.p_ll[LO_W-1:0]};  // low bits need no add.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cross_sum_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// middle stage: folds the two cross products into one sum.
module cross_sum_stage (
    input  logic clk,
    input  logic arst_n,
    pp_if.dst    pp,
    cross_if.src cs
);
    import split_mult_pkg::*;

    cross_sum_t cross_sum;

    // one extra bit keeps the carry.
    assign cross_sum = cross_sum_t'(pp.p_hl) + cross_sum_t'(pp.p_lh);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs.valid   <= 1'b0;
            cs.p_hh    <= '0;
            cs.p_cross <= '0;
            cs.p_ll    <= '0;
        end else begin
            cs.valid   <= pp.valid;
            cs.p_hh    <= pp.p_hh;  // passed on unchanged.
            cs.p_cross <= cross_sum;
            cs.p_ll    <= pp.p_ll;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pp_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module pp_generator #(
    parameter int LO_W = split_mult_pkg::A_LO_DEFAULT
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  split_mult_pkg::operand_t  a,
    input  split_mult_pkg::operand_t  b,
    pp_if.src                         pp
);
    import split_mult_pkg::*;

    localparam int HI_W = OP_W - LO_W;

    logic [HI_W-1:0]      a_hi;
    logic [HI_W-1:0]      b_hi;
    logic [LO_W-1:0]      a_lo;
    logic [LO_W-1:0]      b_lo;
    logic [2*HI_W-1:0]    m_hh;
    logic [HI_W+LO_W-1:0] m_hl;
    logic [LO_W+HI_W-1:0] m_lh;
    logic [2*LO_W-1:0]    m_ll;

    assign a_hi = a[OP_W-1:LO_W];
    assign b_hi = b[OP_W-1:LO_W];
    assign a_lo = a[LO_W-1:0];
    assign b_lo = b[LO_W-1:0];

    sub_mult #(.A_W(HI_W), .B_W(HI_W)) u_hh (
        .a (a_hi),
        .b (b_hi),
        .p (m_hh)
    );

    sub_mult #(.A_W(HI_W), .B_W(LO_W)) u_hl (
        .a (a_hi),
        .b (b_lo),
        .p (m_hl)
    );

    sub_mult #(.A_W(LO_W), .B_W(HI_W)) u_lh (
        .a (a_lo),
        .b (b_hi),
        .p (m_lh)
    );

    sub_mult #(.A_W(LO_W), .B_W(LO_W)) u_ll (
        .a (a_lo),
        .b (b_lo),
        .p (m_ll)
    );

    // first pipeline register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pp.valid <= 1'b0;
            pp.p_hh  <= '0;
            pp.p_hl  <= '0;
            pp.p_lh  <= '0;
            pp.p_ll  <= '0;
        end else begin
            pp.valid <= in_valid;
            pp.p_hh  <= part_prod_t'(m_hh);
            pp.p_hl  <= part_prod_t'(m_hl);  // zero-extended.
            pp.p_lh  <= part_prod_t'(m_lh);
            pp.p_ll  <= part_prod_t'(m_ll);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sub_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

// unsigned A_W x B_W multiplier, split once more into four pieces.
module sub_mult #(
    parameter int A_W = 9,
    parameter int B_W = 9
) (
    input  logic [A_W-1:0]     a,
    input  logic [B_W-1:0]     b,
    output logic [A_W+B_W-1:0] p
);

    localparam int P_W = A_W + B_W;

    generate
        if (A_W == 1) begin : g_a_bit
            assign p = P_W'(b & {B_W{a[0]}});  // single bit is just an and.
        end else if (B_W == 1) begin : g_b_bit
            assign p = P_W'(a & {A_W{b[0]}});
        end else begin : g_split
            // split at half width, high piece gets the odd bit.
            localparam int AL = A_W / 2;
            localparam int AH = A_W - AL;
            localparam int BL = B_W / 2;
            localparam int BH = B_W - BL;

            logic [AH-1:0]    a_hi;
            logic [AL-1:0]    a_lo;
            logic [BH-1:0]    b_hi;
            logic [BL-1:0]    b_lo;
            logic [AH+BH-1:0] m_hh;
            logic [AH+BL-1:0] m_hl;
            logic [AL+BH-1:0] m_lh;
            logic [AL+BL-1:0] m_ll;

            assign a_hi = a[A_W-1:AL];
            assign a_lo = a[AL-1:0];
            assign b_hi = b[B_W-1:BL];
            assign b_lo = b[BL-1:0];

            assign m_hh = a_hi * b_hi;
            assign m_hl = a_hi * b_lo;
            assign m_lh = a_lo * b_hi;
            assign m_ll = a_lo * b_lo;

            // weights are 2^(AL+BL), 2^AL, 2^BL and 1.
            assign p = (P_W'(m_hh) << (AL + BL))
                     + (P_W'(m_hl) << AL)
                     + (P_W'(m_lh) << BL)
                     + P_W'(m_ll);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/pp_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// partial products out of the first stage.
interface pp_if;
    import split_mult_pkg::*;

    part_prod_t p_hh;
    part_prod_t p_hl;
    part_prod_t p_lh;
    part_prod_t p_ll;
    logic       valid;  // data is only meaningful while high.

    modport src (output p_hh, output p_hl, output p_lh, output p_ll, output valid);
    modport dst (input p_hh, input p_hl, input p_lh, input p_ll, input valid);
endinterface

interface cross_if;
    import split_mult_pkg::*;

    part_prod_t p_hh;
    cross_sum_t p_cross;  // hi x lo + lo x hi.
    part_prod_t p_ll;
    logic       valid;

    modport src (output p_hh, output p_cross, output p_ll, output valid);
    modport dst (input p_hh, input p_cross, input p_ll, input valid);
endinterface

`default_nettype wire

// ==== hdl/split_mult_pkg.sv ====
`default_nettype none

package split_mult_pkg;

    // operand and full product widths.
    localparam int OP_W   = 16;
    localparam int PROD_W = 2 * OP_W;

    // operands are split as {hi, lo} with lo taking the low bits.
    localparam int A_LO_DEFAULT = 7;

    // widest sub-product is hi x hi.
    localparam int PART_W = 2 * (OP_W - A_LO_DEFAULT);

    // sum of the two cross products, with its carry.
    localparam int CROSS_W = PART_W + 1;

    typedef logic [OP_W-1:0]    operand_t;
    typedef logic [PROD_W-1:0]  product_t;
    typedef logic [PART_W-1:0]  part_prod_t;  // narrower products are zero-extended.
    typedef logic [CROSS_W-1:0] cross_sum_t;

endpackage

`default_nettype wire
